/* Makefile */
# Verilator build and run of the Sobel testbench
VERILATOR ?= verilator
TOP       ?= sobel_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j $(JOBS)

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
+incdir+hw
hw/sobel_pkg.sv
hw/sobel_fifo.sv
hw/sobel_filter.sv
hw/sobel_regs.sv
hw/sobel_top.sv
testbench/sobel_tb.sv

/* hw/sobel_cfg.svh */
`ifndef SOBEL_CFG_SVH
`define SOBEL_CFG_SVH

// Image geometry in pixels
`define SOBEL_WIDTH  8
`define SOBEL_HEIGHT 6

// Entries per pixel FIFO, power of two
`define SOBEL_FIFO_DEPTH 16

// Register byte offsets on the AXI4-Lite port
`define SOBEL_REG_ENABLE    4'h0
`define SOBEL_REG_THRESHOLD 4'h4
`define SOBEL_REG_FRAMES    4'h8

`endif

/* hw/sobel_fifo.sv */
`timescale 1ns/1ps
`include "sobel_cfg.svh"

module sobel_fifo
    import sobel_pkg::*;
#(
    parameter int DEPTH = `SOBEL_FIFO_DEPTH
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   wr_en,
    input  pixel_t din,
    output logic   full,
    input  logic   rd_en,
    output pixel_t dout,
    output logic   empty
);

    localparam int ADDR_W = $clog2(DEPTH);

    // Pixel storage
    pixel_t mem [DEPTH];

    // Pointers with one extra wrap bit
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            push;
    logic            pop;

    // Only legal transfers move the pointers
    assign push = wr_en && !full;
    assign pop  = rd_en && !empty;

    // Equal pointers mean empty, wrap bits apart mean full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Head word shows at dout without a read strobe
    assign dout = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Producers and consumers honour the flags
    a_no_write_full: assert property (@(posedge clock) disable iff (reset) wr_en |-> !full);
    a_no_read_empty: assert property (@(posedge clock) disable iff (reset) rd_en |-> !empty);

endmodule

/* hw/sobel_filter.sv */
`timescale 1ns/1ps
`include "sobel_cfg.svh"

module sobel_filter
    import sobel_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    output logic   in_rd_en,
    input  logic   in_empty,
    input  pixel_t in_dout,
    output logic   out_wr_en,
    input  logic   out_full,
    output pixel_t out_din,
    input  logic   enable,
    input  pixel_t threshold,
    output logic   frame_done
);

    localparam int WIDTH     = `SOBEL_WIDTH;
    localparam int HEIGHT    = `SOBEL_HEIGHT;
    localparam int PIXELS    = WIDTH * HEIGHT;
    localparam int SHIFT_LEN = 2 * WIDTH + 3;
    localparam int COL_W     = $clog2(WIDTH);
    localparam int ROW_W     = $clog2(HEIGHT);
    localparam int TAKEN_W   = $clog2(PIXELS + 1);

    localparam logic [COL_W-1:0]   LAST_COL = COL_W'(WIDTH - 1);
    localparam logic [ROW_W-1:0]   LAST_ROW = ROW_W'(HEIGHT - 1);
    localparam logic [TAKEN_W-1:0] ALL_IN   = TAKEN_W'(PIXELS);
    localparam logic [TAKEN_W-1:0] PRO_LAST = TAKEN_W'(WIDTH + 1);

    typedef enum logic [1:0] {st_prologue, st_filter, st_output} state_t;

    state_t state;

    // Window of two lines plus three pixels
    // Index 0 holds the oldest pixel
    pixel_t shift_reg [SHIFT_LEN];

    // Real pixels taken from the input FIFO in this frame
    logic [TAKEN_W-1:0] taken;

    // Position of the pixel at the window centre
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;

    // Set while the pending output closes the frame
    logic last_pix;

    grad_t cx;
    grad_t cy;
    grad_t cx_next;
    grad_t cy_next;

    logic        padding;
    logic        step;
    logic        on_border;
    logic [15:0] abs_x;
    logic [15:0] abs_y;
    logic [15:0] grad_sum;
    pixel_t      mag_sat;

    // Weighted column or row of the kernel, a + 2b + c
    function automatic grad_t tap_sum(pixel_t a, pixel_t b, pixel_t c);
        return grad_t'({8'h00, a}) + grad_t'({7'h00, b, 1'b0}) + grad_t'({8'h00, c});
    endfunction

    // Once the whole frame is in, zeros are shifted instead
    assign padding = (taken == ALL_IN);

    // One shift per step and never while an output is pending
    assign step     = enable && (state != st_output) && (padding || !in_empty);
    assign in_rd_en = step && !padding;

    assign on_border = (row == '0) || (row == LAST_ROW) || (col == '0) || (col == LAST_COL);

    // Right column minus left column
    assign cx_next = on_border ? grad_t'(0) :
        tap_sum(shift_reg[2], shift_reg[WIDTH+2], shift_reg[2*WIDTH+2]) -
        tap_sum(shift_reg[0], shift_reg[WIDTH], shift_reg[2*WIDTH]);

    // Bottom row minus top row
    assign cy_next = on_border ? grad_t'(0) :
        tap_sum(shift_reg[2*WIDTH], shift_reg[2*WIDTH+1], shift_reg[2*WIDTH+2]) -
        tap_sum(shift_reg[0], shift_reg[1], shift_reg[2]);

    // Magnitude is half of |cx| + |cy|
    assign abs_x    = cx[15] ? -cx : cx;
    assign abs_y    = cy[15] ? -cy : cy;
    assign grad_sum = abs_x + abs_y;

    // Saturate at full scale
    assign mag_sat = (grad_sum[15:1] > 15'd255) ? 8'hff : grad_sum[8:1];

    // Weak edges are suppressed
    assign out_din    = (mag_sat < threshold) ? 8'h00 : mag_sat;
    assign out_wr_en  = (state == st_output) && !out_full;
    assign frame_done = out_wr_en && last_pix;

    // Window and gradients
    always_ff @(posedge clock) begin
        if (step) begin
            for (int i = 0; i < SHIFT_LEN - 1; i++) begin
                shift_reg[i] <= shift_reg[i+1];
            end
            shift_reg[SHIFT_LEN-1] <= padding ? 8'h00 : in_dout;
        end
        if (step && state == st_filter) begin
            cx <= cx_next;
            cy <= cy_next;
        end
    end

    // FSM and counters
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= st_prologue;
            taken    <= '0;
            col      <= '0;
            row      <= '0;
            last_pix <= 1'b0;
        end else begin
            case (state)
                st_prologue: begin
                    // Fill until the first centre sits at the middle tap
                    if (step) begin
                        taken <= taken + 1'b1;
                        if (taken == PRO_LAST) begin
                            state <= st_filter;
                        end
                    end
                end
                st_filter: begin
                    if (step) begin
                        if (!padding) begin
                            taken <= taken + 1'b1;
                        end
                        last_pix <= (row == LAST_ROW) && (col == LAST_COL);
                        // Raster order wraps to 0,0 after the last pixel
                        if (col == LAST_COL) begin
                            col <= '0;
                            row <= (row == LAST_ROW) ? '0 : row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                        state <= st_output;
                    end
                end
                st_output: begin
                    if (!out_full) begin
                        if (last_pix) begin
                            // Next frame starts with a fresh prologue
                            state <= st_prologue;
                            taken <= '0;
                        end else begin
                            state <= st_filter;
                        end
                    end
                end
                default: begin
                    state <= st_prologue;
                end
            endcase
        end
    end

    // A frame closes only once all its pixels were read
    a_frame_read: assert property (@(posedge clock) disable iff (reset)
        frame_done |-> taken == ALL_IN);

    // Each prologue starts at the frame origin
    a_prologue_origin: assert property (@(posedge clock) disable iff (reset)
        state == st_prologue |-> (row == '0) && (col == '0));

endmodule

/* hw/sobel_pkg.sv */
package sobel_pkg;

    // One grayscale sample
    typedef logic [7:0] pixel_t;

    // Signed horizontal or vertical gradient
    // Worst case magnitude is 4*255, well inside 16 bits
    typedef logic signed [15:0] grad_t;

    // AXI response codes used by the register block
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

endpackage

/* hw/sobel_regs.sv */
`timescale 1ns/1ps
`include "sobel_cfg.svh"

module sobel_regs
    import sobel_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_t   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output axi_resp_t   rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        enable,
    output pixel_t      threshold,
    input  logic        frame_done
);

    logic        wr_fire;
    logic        rd_fire;
    logic [15:0] frames;
    axi_resp_t   wr_resp;
    axi_resp_t   rd_resp;
    logic [31:0] rd_data;

    // Address and data taken together and only with no response pending
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // One read in flight at a time
    assign rd_fire = arvalid && !rvalid;
    assign arready = rd_fire;

    // Write decode
    // FRAMES is read only but answers okay
    always_comb begin
        case (awaddr)
            `SOBEL_REG_ENABLE, `SOBEL_REG_THRESHOLD, `SOBEL_REG_FRAMES: wr_resp = resp_okay;
            default: wr_resp = resp_slverr;
        endcase
    end

    // Read mux
    always_comb begin
        rd_resp = resp_okay;
        case (araddr)
            `SOBEL_REG_ENABLE:    rd_data = {31'h0, enable};
            `SOBEL_REG_THRESHOLD: rd_data = {24'h0, threshold};
            `SOBEL_REG_FRAMES:    rd_data = {16'h0, frames};
            default: begin
                rd_data = 32'h0;
                rd_resp = resp_slverr;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            enable    <= 1'b1;
            threshold <= '0;
            frames    <= '0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            // Both fields live in byte lane 0
            if (wr_fire && wstrb[0]) begin
                if (awaddr == `SOBEL_REG_ENABLE) begin
                    enable <= wdata[0];
                end
                if (awaddr == `SOBEL_REG_THRESHOLD) begin
                    threshold <= wdata[7:0];
                end
            end
            // Completed frames wrap at 16 bits
            if (frame_done) begin
                frames <= frames + 16'd1;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payloads
    always_ff @(posedge clock) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
        if (rd_fire) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // Master keeps a request up until it is taken
    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid);
    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid);

endmodule

/* hw/sobel_top.sv */
`timescale 1ns/1ps

module sobel_top
    import sobel_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_wr_en,
    input  pixel_t      in_din,
    output logic        in_full,
    input  logic        out_rd_en,
    output pixel_t      out_dout,
    output logic        out_empty,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_t   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output axi_resp_t   rresp,
    output logic        rvalid,
    input  logic        rready
);

    // Input FIFO to filter
    pixel_t fifo_in_dout;
    logic   fifo_in_empty;
    logic   fifo_in_rd_en;

    // Filter to output FIFO
    pixel_t fifo_out_din;
    logic   fifo_out_wr_en;
    logic   fifo_out_full;

    // Control between register block and filter
    logic   enable;
    pixel_t threshold;
    logic   frame_done;

    sobel_fifo input_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (fifo_in_rd_en),
        .dout  (fifo_in_dout),
        .empty (fifo_in_empty)
    );

    sobel_filter filter (
        .clock      (clock),
        .reset      (reset),
        .in_rd_en   (fifo_in_rd_en),
        .in_empty   (fifo_in_empty),
        .in_dout    (fifo_in_dout),
        .out_wr_en  (fifo_out_wr_en),
        .out_full   (fifo_out_full),
        .out_din    (fifo_out_din),
        .enable     (enable),
        .threshold  (threshold),
        .frame_done (frame_done)
    );

    sobel_fifo output_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (fifo_out_wr_en),
        .din   (fifo_out_din),
        .full  (fifo_out_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

    sobel_regs regs (
        .clock      (clock),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .enable     (enable),
        .threshold  (threshold),
        .frame_done (frame_done)
    );

endmodule

/* testbench/sobel_tb.sv */
`timescale 1ns/1ps
`include "sobel_cfg.svh"

module sobel_tb
    import sobel_pkg::*;
();

    localparam int WIDTH        = `SOBEL_WIDTH;
    localparam int HEIGHT       = `SOBEL_HEIGHT;
    localparam int PIXELS       = WIDTH * HEIGHT;
    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 3;
    localparam int HIGH_THR     = 40;

    // Cycle budget per test
    // Frames pop roughly one pixel every two clocks
    localparam int REG_TEST_CYCLES   = 60;
    localparam int FRAME_TEST_CYCLES = 4 * PIXELS + 2 * WIDTH + REG_TEST_CYCLES;
    localparam int TOTAL_CYCLES      = RESET_CYCLES + 2 * REG_TEST_CYCLES
                                       + 4 * FRAME_TEST_CYCLES;
    localparam int MARGIN            = 4;

    logic        clock;
    logic        reset;
    logic        in_wr_en;
    pixel_t      in_din;
    logic        in_full;
    logic        out_rd_en;
    pixel_t      out_dout;
    logic        out_empty;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;

    // Current test image, raster order
    pixel_t      frame [PIXELS];
    logic [15:0] lfsr;
    int          frames_expected;

    sobel_top UUT (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t expected);
        if (got !== expected) begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t expected);
        if (got !== expected) begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    // Inputs change one small step after the rising edge
    task automatic next_edge();
        @(posedge clock);
        #(DRIVE_DELAY);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per pixel bit
    task automatic random_frame();
        pixel_t value;
        for (int n = 0; n < PIXELS; n++) begin
            value = '0;
            for (int b = 0; b < 8; b++) begin
                lfsr  = lfsr_next(lfsr);
                value = {value[6:0], lfsr[0]};
            end
            frame[n] = value;
        end
    endtask

    function automatic int pixel_at(input int r, input int c);
        return int'(frame[r * WIDTH + c]);
    endfunction

    // Expected Sobel output for raster position n
    function automatic pixel_t sobel_ref(input int n, input pixel_t thr);
        int r;
        int c;
        int gx;
        int gy;
        int mag;
        r = n / WIDTH;
        c = n % WIDTH;
        if (r == 0 || r == HEIGHT - 1 || c == 0 || c == WIDTH - 1) begin
            return 8'h00;
        end
        gx = pixel_at(r - 1, c + 1) + 2 * pixel_at(r, c + 1) + pixel_at(r + 1, c + 1)
           - pixel_at(r - 1, c - 1) - 2 * pixel_at(r, c - 1) - pixel_at(r + 1, c - 1);
        gy = pixel_at(r + 1, c - 1) + 2 * pixel_at(r + 1, c) + pixel_at(r + 1, c + 1)
           - pixel_at(r - 1, c - 1) - 2 * pixel_at(r - 1, c) - pixel_at(r - 1, c + 1);
        mag = ((gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy)) / 2;
        if (mag > 255) begin
            mag = 255;
        end
        // Weak edges vanish
        if (mag < int'(thr)) begin
            mag = 0;
        end
        return pixel_t'(mag);
    endfunction

    // Ready is sampled at the falling edge before the transfer edge
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        logic seen;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        seen    = 1'b0;
        while (!seen) begin
            @(negedge clock);
            seen = awready && wready;
            next_edge();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        seen    = 1'b0;
        while (!seen) begin
            @(negedge clock);
            seen = bvalid;
            resp = bresp;
            next_edge();
        end
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output axi_resp_t resp);
        logic seen;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        seen    = 1'b0;
        while (!seen) begin
            @(negedge clock);
            seen = arready;
            next_edge();
        end
        arvalid = 1'b0;
        seen    = 1'b0;
        while (!seen) begin
            @(negedge clock);
            seen = rvalid;
            data = rdata;
            resp = rresp;
            next_edge();
        end
        rready = 1'b0;
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] expected,
                               input axi_resp_t expected_resp);
        logic [31:0] data;
        axi_resp_t   resp;
        axi_read(addr, data, resp);
        check_resp("rresp", resp, expected_resp);
        check_word("rdata", data, expected);
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data);
        axi_resp_t resp;
        axi_write(addr, data, resp);
        check_resp("bresp", resp, resp_okay);
    endtask

    // Pushes from pixel first to the end and waits whenever the FIFO is full
    task automatic push_frame(input int first);
        for (int n = first; n < PIXELS; n++) begin
            while (in_full) begin
                in_wr_en = 1'b0;
                next_edge();
            end
            in_din   = frame[n];
            in_wr_en = 1'b1;
            next_edge();
        end
        in_wr_en = 1'b0;
    endtask

    // Pushes from pixel 0 until in_full is seen
    task automatic fill_until_full(output int pushed);
        pushed = 0;
        while (!in_full && pushed < PIXELS) begin
            in_din   = frame[pushed];
            in_wr_en = 1'b1;
            next_edge();
            pushed++;
        end
        in_wr_en = 1'b0;
        if (!in_full) begin
            abort_run("in_full never went high while the frame was pushed");
        end
    endtask

    // Every output of one frame against the model with its borders
    task automatic pop_frame(input pixel_t thr);
        for (int n = 0; n < PIXELS; n++) begin
            while (out_empty) begin
                out_rd_en = 1'b0;
                next_edge();
            end
            check_pixel("out_dout", out_dout, sobel_ref(n, thr));
            out_rd_en = 1'b1;
            next_edge();
        end
        out_rd_en = 1'b0;
    endtask

    task automatic finish_frame(input int first, input pixel_t thr);
        fork
            push_frame(first);
            pop_frame(thr);
        join
        next_edge();
        if (!out_empty) begin
            abort_run("output FIFO holds more pixels than one frame");
        end
        frames_expected++;
        read_expect(`SOBEL_REG_FRAMES, 32'(frames_expected), resp_okay);
    endtask

    task automatic test_reset_values();
        if (!out_empty) begin
            abort_run("out_empty is low after reset");
        end
        if (in_full) begin
            abort_run("in_full is high after reset");
        end
        read_expect(`SOBEL_REG_ENABLE, 32'h1, resp_okay);
        read_expect(`SOBEL_REG_THRESHOLD, 32'h0, resp_okay);
        read_expect(`SOBEL_REG_FRAMES, 32'h0, resp_okay);
        read_expect(4'hc, 32'h0, resp_slverr);
    endtask

    task automatic test_register_access();
        write_expect(`SOBEL_REG_THRESHOLD, 32'h5a);
        read_expect(`SOBEL_REG_THRESHOLD, 32'h5a, resp_okay);
        // Counter is read only
        write_expect(`SOBEL_REG_FRAMES, 32'h1234);
        read_expect(`SOBEL_REG_FRAMES, 32'h0, resp_okay);
    endtask

    task automatic test_frame_plain();
        write_expect(`SOBEL_REG_THRESHOLD, 32'h0);
        random_frame();
        finish_frame(0, 8'h00);
    endtask

    task automatic test_frame_threshold();
        write_expect(`SOBEL_REG_THRESHOLD, 32'(HIGH_THR));
        random_frame();
        // Faint vertical edge around pixel (2,2) with magnitude 20
        for (int r = 1; r <= 3; r++) begin
            for (int c = 1; c <= 3; c++) begin
                frame[r * WIDTH + c] = (c == 3) ? 8'd110 : 8'd100;
            end
        end
        finish_frame(0, pixel_t'(HIGH_THR));
    endtask

    // Output not read until the input side backs up
    task automatic test_back_pressure();
        int pushed;
        out_rd_en = 1'b0;
        random_frame();
        fill_until_full(pushed);
        finish_frame(pushed, pixel_t'(HIGH_THR));
    endtask

    task automatic test_enable_stall();
        int pushed;
        write_expect(`SOBEL_REG_ENABLE, 32'h0);
        random_frame();
        fill_until_full(pushed);
        repeat (2 * WIDTH) next_edge();
        if (!out_empty) begin
            abort_run("filter produced output while disabled");
        end
        write_expect(`SOBEL_REG_ENABLE, 32'h1);
        finish_frame(pushed, pixel_t'(HIGH_THR));
    endtask

    initial begin
        reset           = 1'b1;
        in_wr_en        = 1'b0;
        in_din          = '0;
        out_rd_en       = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wstrb           = '0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        lfsr            = 16'd3;
        frames_expected = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset = 1'b0;
        next_edge();
        test_reset_values();
        test_register_access();
        test_frame_plain();
        test_frame_threshold();
        test_back_pressure();
        test_enable_stall();
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * MARGIN);
        abort_run("Timeout: the tests did not finish within the time limit");
    end

endmodule
